// ==== hw/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Bus widths.
`define MEM_ADDR_W      32
`define MEM_DATA_W      32
`define MEM_SEL_W       4

// Process ID relocation.
`define MEM_PID_W       8
`define MEM_PID_SHIFT   25      // PID lands in the top address bits.

// Posted write entries, power of two.
`define STORE_BUF_DEPTH 16

`endif

// ==== hw/bus_pkg.sv ====
package bus_pkg;

        // Operation carried from the merger to the adapter.
        typedef enum logic {
                OP_READ  = 1'b0,
                OP_WRITE = 1'b1
        } bus_op_t;

        // Wishbone master state.
        typedef enum logic [1:0] {
                WB_IDLE  = 2'd0,
                WB_WRITE = 2'd1,        // Draining one store buffer entry.
                WB_READ  = 2'd2
        } wb_state_t;

endpackage

// ==== hw/port_pkg.sv ====
package port_pkg;

        // Which core port a request or ack belongs to.
        typedef enum logic {
                SRC_CODE = 1'b0,
                SRC_DATA = 1'b1
        } src_t;

        // Merger grant state.
        typedef enum logic [1:0] {
                GNT_NONE = 2'd0,
                GNT_CODE = 2'd1,
                GNT_DATA = 2'd2
        } grant_t;

endpackage

// ==== hw/req_stage.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module req_stage (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [`MEM_PID_W-1:0]   i_pid,
        // Core code port.
        input  logic                    i_code_valid,
        input  logic [`MEM_ADDR_W-1:0]  i_code_adr,
        output logic                    o_code_ready,
        // Core data port.
        input  logic                    i_data_valid,
        input  logic                    i_data_we,
        input  logic [`MEM_ADDR_W-1:0]  i_data_adr,
        input  logic [`MEM_SEL_W-1:0]   i_data_sel,
        input  logic [`MEM_DATA_W-1:0]  i_data_wdat,
        output logic                    o_data_ready,
        // Toward the merger.
        output logic                    o_c_valid,
        output logic [`MEM_ADDR_W-1:0]  o_c_adr,
        input  logic                    i_c_ready,
        input  logic                    i_c_ack,
        output logic                    o_d_valid,
        output logic                    o_d_we,
        output logic [`MEM_ADDR_W-1:0]  o_d_adr,
        output logic [`MEM_SEL_W-1:0]   o_d_sel,
        output logic [`MEM_DATA_W-1:0]  o_d_wdat,
        input  logic                    i_d_ready,
        input  logic                    i_d_ack
);

logic                   c_busy, d_busy;         // Request held until its ack.
logic                   c_take, d_take;
logic [`MEM_ADDR_W-1:0] pid_off;

assign pid_off = {{(`MEM_ADDR_W-`MEM_PID_W){1'b0}}, i_pid} << `MEM_PID_SHIFT;
assign c_take  = i_code_valid && o_code_ready;
assign d_take  = i_data_valid && o_data_ready;

// Port control. o_*_valid drops once the merger takes it, busy drops on ack.
always_ff @(posedge i_clk) begin
        if (i_reset) begin
                c_busy       <= 1'b0;
                d_busy       <= 1'b0;
                o_c_valid    <= 1'b0;
                o_d_valid    <= 1'b0;
                o_code_ready <= 1'b0;
                o_data_ready <= 1'b0;
        end else begin
                if (c_take) begin
                        c_busy    <= 1'b1;
                        o_c_valid <= 1'b1;
                end else begin
                        if (o_c_valid && i_c_ready)
                                o_c_valid <= 1'b0;
                        if (i_c_ack)
                                c_busy <= 1'b0;
                end
                if (d_take) begin
                        d_busy    <= 1'b1;
                        o_d_valid <= 1'b1;
                end else begin
                        if (o_d_valid && i_d_ready)
                                o_d_valid <= 1'b0;
                        if (i_d_ack)
                                d_busy <= 1'b0;
                end
                o_code_ready <= !c_take && (!c_busy || i_c_ack); // Idle next cycle.
                o_data_ready <= !d_take && (!d_busy || i_d_ack);
        end
end

// Captured payload with relocation applied.
always_ff @(posedge i_clk) begin
        if (c_take)
                o_c_adr <= {i_code_adr[`MEM_ADDR_W-1:2], 2'b00} + pid_off; // Word aligned.
        if (d_take) begin
                o_d_we   <= i_data_we;
                o_d_adr  <= i_data_adr + pid_off;
                o_d_sel  <= i_data_sel;
                o_d_wdat <= i_data_wdat;
        end
end

// Acks come back through merger and adapter, so they must match a held request.
a_code_ack_busy: assert property (@(posedge i_clk) disable iff (i_reset) i_c_ack |-> c_busy);
a_data_ack_busy: assert property (@(posedge i_clk) disable iff (i_reset) i_d_ack |-> d_busy);

endmodule

// ==== hw/port_merger.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module port_merger (
        input  logic                    i_clk,
        input  logic                    i_reset,
        // Code side.
        input  logic                    i_c_valid,
        input  logic [`MEM_ADDR_W-1:0]  i_c_adr,
        output logic                    o_c_ready,
        output logic                    o_c_ack,
        // Data side.
        input  logic                    i_d_valid,
        input  logic                    i_d_we,
        input  logic [`MEM_ADDR_W-1:0]  i_d_adr,
        input  logic [`MEM_SEL_W-1:0]   i_d_sel,
        input  logic [`MEM_DATA_W-1:0]  i_d_wdat,
        output logic                    o_d_ready,
        output logic                    o_d_ack,
        // Toward the adapter.
        output logic                    o_valid,
        output bus_pkg::bus_op_t        o_op,
        output port_pkg::src_t          o_src,
        output logic [`MEM_ADDR_W-1:0]  o_adr,
        output logic [`MEM_SEL_W-1:0]   o_sel,
        output logic [`MEM_DATA_W-1:0]  o_wdat,
        input  logic                    i_ready,
        input  logic                    i_ack,
        input  port_pkg::src_t          i_ack_src
);

port_pkg::grant_t       r_grant;
port_pkg::src_t         r_last;         // Port served last.

// Grant FSM. Returns to GNT_NONE after every transfer.
always_ff @(posedge i_clk) begin
        if (i_reset) begin
                r_grant <= port_pkg::GNT_NONE;
                r_last  <= port_pkg::SRC_DATA;  // Code wins the first tie.
        end else begin
                case (r_grant)
                port_pkg::GNT_NONE: begin
                        if (i_c_valid && (!i_d_valid || r_last == port_pkg::SRC_DATA))
                                r_grant <= port_pkg::GNT_CODE;
                        else if (i_d_valid)
                                r_grant <= port_pkg::GNT_DATA;
                end
                port_pkg::GNT_CODE: begin
                        if (i_c_valid && i_ready) begin
                                r_grant <= port_pkg::GNT_NONE;
                                r_last  <= port_pkg::SRC_CODE;
                        end
                end
                port_pkg::GNT_DATA: begin
                        if (i_d_valid && i_ready) begin
                                r_grant <= port_pkg::GNT_NONE;
                                r_last  <= port_pkg::SRC_DATA;
                        end
                end
                default: r_grant <= port_pkg::GNT_NONE;
                endcase
        end
end

// Payload mux.
always_comb begin
        o_valid = 1'b0;
        o_op    = bus_pkg::OP_READ;     // Code only fetches.
        o_src   = port_pkg::SRC_CODE;
        o_adr   = i_c_adr;
        o_sel   = '1;                   // Full word.
        o_wdat  = '0;
        if (r_grant == port_pkg::GNT_CODE) begin
                o_valid = i_c_valid;
        end else if (r_grant == port_pkg::GNT_DATA) begin
                o_valid = i_d_valid;
                o_op    = i_d_we ? bus_pkg::OP_WRITE : bus_pkg::OP_READ;
                o_src   = port_pkg::SRC_DATA;
                o_adr   = i_d_adr;
                o_sel   = i_d_sel;
                o_wdat  = i_d_wdat;
        end
end

assign o_c_ready = (r_grant == port_pkg::GNT_CODE) && i_ready;
assign o_d_ready = (r_grant == port_pkg::GNT_DATA) && i_ready;

// Ack demux by tag.
assign o_c_ack = i_ack && (i_ack_src == port_pkg::SRC_CODE);
assign o_d_ack = i_ack && (i_ack_src == port_pkg::SRC_DATA);

// A granted port keeps its request up until the transfer.
a_c_ready_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_c_ready |-> i_c_valid);
a_d_ready_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_d_ready |-> i_d_valid);

endmodule

// ==== hw/wb_store_adapter.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module wb_store_adapter (
        input  logic                    i_clk,
        input  logic                    i_reset,
        // From the merger.
        input  logic                    i_valid,
        input  bus_pkg::bus_op_t        i_op,
        input  port_pkg::src_t          i_src,
        input  logic [`MEM_ADDR_W-1:0]  i_adr,
        input  logic [`MEM_SEL_W-1:0]   i_sel,
        input  logic [`MEM_DATA_W-1:0]  i_wdat,
        output logic                    o_ready,
        output logic                    o_ack,
        output port_pkg::src_t          o_ack_src,
        output logic [`MEM_DATA_W-1:0]  o_rdata,
        // Wishbone master.
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic                    o_wb_we,
        output logic [`MEM_ADDR_W-1:0]  o_wb_adr,
        output logic [`MEM_SEL_W-1:0]   o_wb_sel,
        output logic [`MEM_DATA_W-1:0]  o_wb_dat,
        input  logic                    i_wb_ack,
        input  logic [`MEM_DATA_W-1:0]  i_wb_dat
);

localparam int                  PTR_W    = $clog2(`STORE_BUF_DEPTH);
localparam logic [PTR_W:0]      FULL_CNT = `STORE_BUF_DEPTH;

logic [`MEM_ADDR_W-1:0] buf_adr [`STORE_BUF_DEPTH];
logic [`MEM_SEL_W-1:0]  buf_sel [`STORE_BUF_DEPTH];
logic [`MEM_DATA_W-1:0] buf_dat [`STORE_BUF_DEPTH];
logic [PTR_W-1:0]       wr_ptr, rd_ptr;
logic [PTR_W:0]         count;
bus_pkg::wb_state_t     state;
port_pkg::src_t         rd_src;         // Owner of the read on the bus.
logic                   fifo_full, fifo_empty;
logic                   push, pop, take_rd, rd_done;

assign fifo_full  = (count == FULL_CNT);
assign fifo_empty = (count == '0);

// Reads wait for an empty buffer so they see every earlier store.
// Writes wait out a read so the two acks never land together.
assign o_ready = (i_op == bus_pkg::OP_WRITE) ?
                 (!fifo_full && state != bus_pkg::WB_READ) :
                 (fifo_empty && state == bus_pkg::WB_IDLE);

assign push    = i_valid && o_ready && (i_op == bus_pkg::OP_WRITE);
assign take_rd = i_valid && o_ready && (i_op == bus_pkg::OP_READ);
assign pop     = (state == bus_pkg::WB_IDLE) && !fifo_empty;
assign rd_done = (state == bus_pkg::WB_READ) && i_wb_ack;

// Store buffer.
always_ff @(posedge i_clk) begin
        if (push) begin
                buf_adr[wr_ptr] <= i_adr;
                buf_sel[wr_ptr] <= i_sel;
                buf_dat[wr_ptr] <= i_wdat;
        end
end

always_ff @(posedge i_clk) begin
        if (i_reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
        end else begin
                if (push)
                        wr_ptr <= wr_ptr + 1'b1;
                if (pop)
                        rd_ptr <= rd_ptr + 1'b1;
                case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
                endcase
        end
end

// Bus FSM and ack generation.
always_ff @(posedge i_clk) begin
        if (i_reset) begin
                state    <= bus_pkg::WB_IDLE;
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_ack    <= 1'b0;
        end else begin
                o_ack <= push || rd_done;       // Posted writes ack right away.
                case (state)
                bus_pkg::WB_IDLE: begin
                        if (take_rd) begin
                                state    <= bus_pkg::WB_READ;
                                o_wb_cyc <= 1'b1;
                                o_wb_stb <= 1'b1;
                        end else if (pop) begin
                                state    <= bus_pkg::WB_WRITE;
                                o_wb_cyc <= 1'b1;
                                o_wb_stb <= 1'b1;
                        end
                end
                bus_pkg::WB_WRITE, bus_pkg::WB_READ: begin
                        if (i_wb_ack) begin
                                state    <= bus_pkg::WB_IDLE;
                                o_wb_cyc <= 1'b0;
                                o_wb_stb <= 1'b0;
                        end
                end
                default: state <= bus_pkg::WB_IDLE;
                endcase
        end
end

// Cycle payload and response data.
always_ff @(posedge i_clk) begin
        if (take_rd) begin
                o_wb_we  <= 1'b0;
                o_wb_adr <= i_adr;
                o_wb_sel <= i_sel;
                o_wb_dat <= i_wdat;
                rd_src   <= i_src;
        end else if (pop) begin
                o_wb_we  <= 1'b1;
                o_wb_adr <= buf_adr[rd_ptr];
                o_wb_sel <= buf_sel[rd_ptr];
                o_wb_dat <= buf_dat[rd_ptr];
        end
        if (rd_done)
                o_rdata <= i_wb_dat;
        if (push)
                o_ack_src <= i_src;
        else if (rd_done)
                o_ack_src <= rd_src;
end

// Bus payload holds until the slave acks.
a_wb_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb_stb && !i_wb_ack |=> $stable({o_wb_we, o_wb_adr, o_wb_sel, o_wb_dat}));
// A read goes out only with the store buffer drained.
a_rd_drained: assert property (@(posedge i_clk) disable iff (i_reset)
        state == bus_pkg::WB_READ |-> fifo_empty);

endmodule

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_subsys_top (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [`MEM_PID_W-1:0]   i_pid,
        // Core code port.
        input  logic                    i_code_valid,
        input  logic [`MEM_ADDR_W-1:0]  i_code_adr,
        output logic                    o_code_ready,
        output logic                    o_code_ack,
        output logic [`MEM_DATA_W-1:0]  o_code_rdata,
        // Core data port.
        input  logic                    i_data_valid,
        input  logic                    i_data_we,
        input  logic [`MEM_ADDR_W-1:0]  i_data_adr,
        input  logic [`MEM_SEL_W-1:0]   i_data_sel,
        input  logic [`MEM_DATA_W-1:0]  i_data_wdat,
        output logic                    o_data_ready,
        output logic                    o_data_ack,
        output logic [`MEM_DATA_W-1:0]  o_data_rdata,
        // Wishbone.
        output logic                    o_wb_cyc,
        output logic                    o_wb_stb,
        output logic                    o_wb_we,
        output logic [`MEM_ADDR_W-1:0]  o_wb_adr,
        output logic [`MEM_SEL_W-1:0]   o_wb_sel,
        output logic [`MEM_DATA_W-1:0]  o_wb_dat,
        input  logic                    i_wb_ack,
        input  logic [`MEM_DATA_W-1:0]  i_wb_dat
);

logic                   reset;
logic                   c_valid, c_ready;
logic [`MEM_ADDR_W-1:0] c_adr;
logic                   d_valid, d_we, d_ready;
logic [`MEM_ADDR_W-1:0] d_adr;
logic [`MEM_SEL_W-1:0]  d_sel;
logic [`MEM_DATA_W-1:0] d_wdat;
logic                   m_valid, m_ready, m_ack;
bus_pkg::bus_op_t       m_op;
port_pkg::src_t         m_src, m_ack_src;
logic [`MEM_ADDR_W-1:0] m_adr;
logic [`MEM_SEL_W-1:0]  m_sel;
logic [`MEM_DATA_W-1:0] m_wdat, m_rdata;

// Internal reset, one cycle behind the pin.
always_ff @(posedge i_clk)
        reset <= i_reset;

// Both ports share the adapter's read register, the ack says who owns it.
assign o_code_rdata = m_rdata;
assign o_data_rdata = m_rdata;

req_stage u_req_stage (
        .i_clk(i_clk), .i_reset(reset), .i_pid(i_pid),
        .i_code_valid(i_code_valid), .i_code_adr(i_code_adr), .o_code_ready(o_code_ready),
        .i_data_valid(i_data_valid), .i_data_we(i_data_we), .i_data_adr(i_data_adr),
        .i_data_sel(i_data_sel), .i_data_wdat(i_data_wdat), .o_data_ready(o_data_ready),
        .o_c_valid(c_valid), .o_c_adr(c_adr), .i_c_ready(c_ready), .i_c_ack(o_code_ack),
        .o_d_valid(d_valid), .o_d_we(d_we), .o_d_adr(d_adr), .o_d_sel(d_sel),
        .o_d_wdat(d_wdat), .i_d_ready(d_ready), .i_d_ack(o_data_ack)
);

// Acks from the merger go to the core and back to req_stage.
port_merger u_port_merger (
        .i_clk(i_clk), .i_reset(reset),
        .i_c_valid(c_valid), .i_c_adr(c_adr), .o_c_ready(c_ready), .o_c_ack(o_code_ack),
        .i_d_valid(d_valid), .i_d_we(d_we), .i_d_adr(d_adr), .i_d_sel(d_sel),
        .i_d_wdat(d_wdat), .o_d_ready(d_ready), .o_d_ack(o_data_ack),
        .o_valid(m_valid), .o_op(m_op), .o_src(m_src), .o_adr(m_adr), .o_sel(m_sel),
        .o_wdat(m_wdat), .i_ready(m_ready), .i_ack(m_ack), .i_ack_src(m_ack_src)
);

wb_store_adapter u_wb_store_adapter (
        .i_clk(i_clk), .i_reset(reset),
        .i_valid(m_valid), .i_op(m_op), .i_src(m_src), .i_adr(m_adr), .i_sel(m_sel),
        .i_wdat(m_wdat), .o_ready(m_ready), .o_ack(m_ack), .o_ack_src(m_ack_src),
        .o_rdata(m_rdata),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we), .o_wb_adr(o_wb_adr),
        .o_wb_sel(o_wb_sel), .o_wb_dat(o_wb_dat), .i_wb_ack(i_wb_ack), .i_wb_dat(i_wb_dat)
);

endmodule

// ==== verification/wb_mem_model.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module wb_mem_model (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_cyc,
        input  logic                    i_stb,
        input  logic                    i_we,
        input  logic [`MEM_ADDR_W-1:0]  i_adr,
        input  logic [`MEM_SEL_W-1:0]   i_sel,
        input  logic [`MEM_DATA_W-1:0]  i_dat,
        input  logic                    i_ack_hold,     // Stalls the ack while high.
        output logic                    o_ack,
        output logic [`MEM_DATA_W-1:0]  o_dat
);

logic [`MEM_DATA_W-1:0] mem [logic [`MEM_ADDR_W-1:0]];  // Keyed by word byte address.
logic                   busy;
int unsigned            delay;

function automatic logic [`MEM_DATA_W-1:0] read_word(input logic [`MEM_ADDR_W-1:0] key);
        if (mem.exists(key))
                return mem[key];
        return key ^ 32'h5a5a_5a5a;     // Unwritten fill.
endfunction

// One registered ack per strobe, after a random wait.
always @(posedge i_clk) begin
        logic [`MEM_ADDR_W-1:0] key;
        logic [`MEM_DATA_W-1:0] word;
        key   = {i_adr[`MEM_ADDR_W-1:2], 2'b00};
        o_ack <= 1'b0;
        if (i_reset) begin
                busy <= 1'b0;
        end else if (i_cyc && i_stb && !o_ack) begin
                if (!busy) begin
                        busy  <= 1'b1;
                        delay <= $urandom_range(3, 0);
                end else if (delay != 0) begin
                        delay <= delay - 1;
                end else if (!i_ack_hold) begin
                        word = read_word(key);
                        for (int b = 0; b < `MEM_SEL_W; b++)
                                if (i_we && i_sel[b])
                                        word[8*b +: 8] = i_dat[8*b +: 8];
                        if (i_we)
                                mem[key] = word;
                        o_dat <= word;
                        o_ack <= 1'b1;
                        busy  <= 1'b0;
                end
        end
end

endmodule

// ==== verification/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsys;

localparam int CLK_NS       = 8;
localparam int RESET_CYCLES = 5;
localparam int MAX_WAIT     = 400;      // Cycles allowed for one handshake or ack.
localparam int RAND_PAIRS   = 32;
localparam int NUM_TESTS    = 5;
localparam int TEST_CYCLES  = 2 * RAND_PAIRS * MAX_WAIT;        // Longest test, worst case.
localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_NS;

logic                   clk, reset, ack_hold;
logic [`MEM_PID_W-1:0]  pid;
logic                   code_valid, code_ready, code_ack;
logic [`MEM_ADDR_W-1:0] code_adr;
logic [`MEM_DATA_W-1:0] code_rdata;
logic                   data_valid, data_we, data_ready, data_ack;
logic [`MEM_ADDR_W-1:0] data_adr;
logic [`MEM_SEL_W-1:0]  data_sel;
logic [`MEM_DATA_W-1:0] data_wdat, data_rdata;
logic                   wb_cyc, wb_stb, wb_we, wb_ack;
logic [`MEM_ADDR_W-1:0] wb_adr;
logic [`MEM_SEL_W-1:0]  wb_sel;
logic [`MEM_DATA_W-1:0] wb_dat, wb_rdat;

logic [`MEM_DATA_W-1:0] ref_mem [logic [`MEM_ADDR_W-1:0]];     // Expected memory image.
int                     code_reqs, data_reqs, code_acks, data_acks, wb_acks;
logic                   watch_on;
logic [`MEM_ADDR_W-1:0] watch_adr;
int                     watch_hits;

mem_subsys_top dut (
        .i_clk(clk), .i_reset(reset), .i_pid(pid),
        .i_code_valid(code_valid), .i_code_adr(code_adr), .o_code_ready(code_ready),
        .o_code_ack(code_ack), .o_code_rdata(code_rdata),
        .i_data_valid(data_valid), .i_data_we(data_we), .i_data_adr(data_adr),
        .i_data_sel(data_sel), .i_data_wdat(data_wdat), .o_data_ready(data_ready),
        .o_data_ack(data_ack), .o_data_rdata(data_rdata),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we), .o_wb_adr(wb_adr),
        .o_wb_sel(wb_sel), .o_wb_dat(wb_dat), .i_wb_ack(wb_ack), .i_wb_dat(wb_rdat)
);

wb_mem_model u_wb_mem (
        .i_clk(clk), .i_reset(reset), .i_cyc(wb_cyc), .i_stb(wb_stb), .i_we(wb_we),
        .i_adr(wb_adr), .i_sel(wb_sel), .i_dat(wb_dat), .i_ack_hold(ack_hold),
        .o_ack(wb_ack), .o_dat(wb_rdat)
);

initial clk = 1'b0;
always #(CLK_NS / 2) clk = ~clk;

task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
                $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
                stop_run();
        end
endtask

// PID relocation as seen on the bus.
function automatic logic [31:0] reloc(input logic [31:0] adr);
        return adr + ({{(`MEM_ADDR_W-`MEM_PID_W){1'b0}}, pid} << `MEM_PID_SHIFT);
endfunction

function automatic logic [31:0] ref_read(input logic [31:0] adr);
        logic [31:0] key;
        key = {adr[31:2], 2'b00};
        if (ref_mem.exists(key))
                return ref_mem[key];
        return key ^ 32'h5a5a_5a5a;
endfunction

function automatic void ref_write(input logic [31:0] adr, input logic [3:0] sel,
                                  input logic [31:0] dat);
        logic [31:0] word;
        word = ref_read(adr);
        for (int b = 0; b < 4; b++)
                if (sel[b])
                        word[8*b +: 8] = dat[8*b +: 8];
        ref_mem[{adr[31:2], 2'b00}] = word;
endfunction

// Called right after a rising edge.
task automatic code_read(input logic [31:0] adr, output logic [31:0] rdata);
        int waited;
        code_reqs++;
        code_valid <= 1'b1;
        code_adr   <= adr;
        waited = 0;
        do begin
                @(posedge clk);
                waited++;
        end while (code_ready !== 1'b1 && waited < MAX_WAIT);
        assert (code_ready === 1'b1) else begin
                $display("code request was not accepted within %0d cycles", MAX_WAIT);
                stop_run();
        end
        code_valid <= 1'b0;
        waited = 0;
        do begin
                @(posedge clk);
                waited++;
        end while (code_ack !== 1'b1 && waited < MAX_WAIT);
        assert (code_ack === 1'b1) else begin
                $display("no code ack within %0d cycles", MAX_WAIT);
                stop_run();
        end
        rdata = code_rdata;
endtask

task automatic data_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] wdat, output logic [31:0] rdata);
        int waited;
        data_reqs++;
        data_valid <= 1'b1;
        data_we    <= we;
        data_adr   <= adr;
        data_sel   <= sel;
        data_wdat  <= wdat;
        waited = 0;
        do begin
                @(posedge clk);
                waited++;
        end while (data_ready !== 1'b1 && waited < MAX_WAIT);
        assert (data_ready === 1'b1) else begin
                $display("data request was not accepted within %0d cycles", MAX_WAIT);
                stop_run();
        end
        data_valid <= 1'b0;
        if (we)
                ref_write(reloc(adr), sel, wdat);
        waited = 0;
        do begin
                @(posedge clk);
                waited++;
        end while (data_ack !== 1'b1 && waited < MAX_WAIT);
        assert (data_ack === 1'b1) else begin
                $display("no data ack within %0d cycles", MAX_WAIT);
                stop_run();
        end
        rdata = data_rdata;
endtask

// Bus watch for code fetches and ack counters.
always @(posedge clk) begin
        if (watch_on && wb_stb === 1'b1) begin
                watch_hits++;
                check_value("o_wb_adr", wb_adr, watch_adr);
                check_value("o_wb_we", wb_we, 0);
                check_value("o_wb_sel", wb_sel, 4'hf);
        end
        if (code_ack === 1'b1)
                code_acks++;
        if (data_ack === 1'b1)
                data_acks++;
        if (wb_ack === 1'b1)
                wb_acks++;
end

task automatic test_reset_state();
        int waited;
        waited = 0;
        do begin
                @(posedge clk);
                waited++;
                check_value("o_wb_cyc", wb_cyc, 0);
                check_value("o_wb_stb", wb_stb, 0);
                check_value("o_code_ack", code_ack, 0);
                check_value("o_data_ack", data_ack, 0);
        end while (!(code_ready === 1'b1 && data_ready === 1'b1) && waited < MAX_WAIT);
        assert (code_ready === 1'b1 && data_ready === 1'b1) else begin
                $display("ready outputs did not rise after reset");
                stop_run();
        end
endtask

task automatic test_code_reloc();
        logic [31:0] rdata;
        pid <= 8'h03;
        @(posedge clk);
        watch_adr  = reloc(32'h0000_1234);      // Low bits of 0x1236 dropped.
        watch_hits = 0;
        watch_on   = 1'b1;
        code_read(32'h0000_1236, rdata);
        watch_on   = 1'b0;
        assert (watch_hits > 0) else begin
                $display("the code read never strobed the Wishbone bus");
                stop_run();
        end
        check_value("o_code_rdata", rdata, 32'h0600_1234 ^ 32'h5a5a_5a5a);
endtask

task automatic test_partial_writes();
        logic [31:0] rdata;
        pid <= 8'h11;
        @(posedge clk);
        data_access(1'b1, 32'h0000_0400, 4'b0011, 32'hdead_beef, rdata);
        data_access(1'b1, 32'h0000_0400, 4'b1000, 32'h7700_0000, rdata);
        data_access(1'b1, 32'h0000_0400, 4'b0100, 32'h0055_0000, rdata);
        data_access(1'b0, 32'h0000_0400, 4'b1111, 32'h0, rdata);
        check_value("o_data_rdata", rdata, 32'h7755_beef);     // Fill 0x785a5e5a merged.
endtask

task automatic test_store_backpressure();
        logic [31:0] rdata;
        logic        blocked_done;
        int          wb_before;
        ack_hold <= 1'b1;
        @(posedge clk);
        wb_before = wb_acks;
        // One write stalls on the bus, the buffer takes STORE_BUF_DEPTH more.
        for (int i = 0; i <= `STORE_BUF_DEPTH; i++)
                data_access(1'b1, 32'h0000_2000 + 4 * i, 4'hf, $urandom, rdata);
        // First write still waits on the bus.
        check_value("o_wb_stb", wb_stb, 1);
        check_value("o_wb_we", wb_we, 1);
        check_value("o_wb_adr", wb_adr, reloc(32'h0000_2000));
        check_value("o_wb_sel", wb_sel, 4'hf);
        check_value("o_wb_dat", wb_dat, ref_read(reloc(32'h0000_2000)));
        blocked_done = 1'b0;
        fork
                begin
                        data_access(1'b1, 32'h0000_2000 + 4 * (`STORE_BUF_DEPTH + 1), 4'hf,
                                    $urandom, rdata);
                        blocked_done = 1'b1;
                end
                begin
                        repeat (20) @(posedge clk);
                        check_value("o_data_ready", data_ready, 0);
                        assert (!blocked_done) else begin
                                $display("write was acked while the store buffer was full");
                                stop_run();
                        end
                        ack_hold <= 1'b0;
                end
        join
        data_access(1'b0, 32'h0000_2000, 4'hf, 32'h0, rdata);
        check_value("o_data_rdata", rdata, ref_read(reloc(32'h0000_2000)));
        data_access(1'b0, 32'h0000_2000 + 4 * (`STORE_BUF_DEPTH + 1), 4'hf, 32'h0, rdata);
        check_value("o_data_rdata", rdata,
                    ref_read(reloc(32'h0000_2000 + 4 * (`STORE_BUF_DEPTH + 1))));
        // Each posted write and both reads ran once on the bus.
        check_value("wb ack count", wb_acks - wb_before, `STORE_BUF_DEPTH + 4);
endtask

task automatic test_concurrent_reads();
        logic [31:0] c_adr, d_adr, c_data, d_data;
        for (int n = 0; n < RAND_PAIRS; n++) begin
                pid   <= (n % 4 == 0) ? 8'h11 : $urandom;
                c_adr = $urandom;
                d_adr = (n % 4 == 0) ? 32'h0000_0400 : $urandom; // Some hit written words.
                @(posedge clk);
                fork
                        code_read(c_adr, c_data);
                        data_access(1'b0, d_adr, 4'hf, 32'h0, d_data);
                join
                check_value("o_code_rdata", c_data, ref_read(reloc({c_adr[31:2], 2'b00})));
                check_value("o_data_rdata", d_data, ref_read(reloc(d_adr)));
        end
        repeat (4) @(posedge clk);
        check_value("code ack count", code_acks, code_reqs);
        check_value("data ack count", data_acks, data_reqs);
endtask

initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
end

initial begin
        void'($urandom(32'hd2a32db0));
        reset      = 1'b1;
        ack_hold   = 1'b0;
        pid        = '0;
        code_valid = 1'b0;
        code_adr   = '0;
        data_valid = 1'b0;
        data_we    = 1'b0;
        data_adr   = '0;
        data_sel   = '0;
        data_wdat  = '0;
        watch_on   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_code_reloc();
        test_partial_writes();
        test_store_backpressure();
        test_concurrent_reads();
        $display("RESULT: PASS");
        $finish;
end

endmodule

// ==== src.f ====
+incdir+hw
hw/bus_pkg.sv
hw/port_pkg.sv
hw/req_stage.sv
hw/port_merger.sv
hw/wb_store_adapter.sv
hw/mem_subsys_top.sv
verification/wb_mem_model.sv
verification/tb_mem_subsys.sv
